//--- Bender.yml
package:
  name: xvid_video_gen

sources:
  - xvid_pkg.sv
  - video_timing.sv
  - video_regs.sv
  - video_bitmap.sv
  - video_gen.sv
  - target: simulation
    files:
      - tb_vram_model.sv
      - tb_video_gen.sv

//--- list.f
xvid_pkg.sv
video_timing.sv
video_regs.sv
video_bitmap.sv
video_gen.sv
tb_vram_model.sv
tb_video_gen.sv

//--- tb_video_gen.sv
// tb_video_gen
// directed testbench for the bitmap video generator covering register
// access, captured frames against the playfield rule, sync and interrupt timing
`default_nettype none
`timescale 1ns/1ps

module tb_video_gen;

localparam int CLK_PERIOD   = 4;
localparam int RESET_CYCLES = 8;
localparam int FRAME_CYCLES = xvid_pkg::H_TOTAL * xvid_pkg::V_TOTAL;
localparam int FRAME_PIX    = xvid_pkg::H_VISIBLE * xvid_pkg::V_VISIBLE;
localparam int VIDEO_LAT    = 2;                        // timing to video outputs
localparam int WATCHDOG_NS  = (40 * FRAME_CYCLES + RESET_CYCLES) * CLK_PERIOD;
localparam logic [15:0] HRES_MASK = (1 << xvid_pkg::HRES_W) - 1;

logic                   clk = 1'b0;
logic                   reset_i;
logic                   reg_wr_en_i;
logic [5:0]             reg_num_i;
xvid_pkg::word_t        reg_data_i;
xvid_pkg::word_t        reg_data_o;
logic                   video_intr_o;
logic                   vram_sel_o;
xvid_pkg::addr_t        vram_addr_o;
xvid_pkg::word_t        vram_data;
xvid_pkg::color_t       color_index_o;
logic                   hsync_o;
logic                   vsync_o;
logic                   dv_de_o;
logic                   h_blank_o;
logic                   v_blank_o;

int                     errors = 0;
logic [15:0]            lfsr_state = 16'd5983;
xvid_pkg::color_t       frame_pix [FRAME_PIX];

// expected configuration as last written
logic [7:0]             cfg_border;
logic [4:0]             cfg_left;
logic [4:0]             cfg_right;
logic [15:0]            cfg_start;
logic [15:0]            cfg_len;
logic [7:0]             cfg_cb;
logic                   cfg_blank;

always #(CLK_PERIOD / 2) clk = ~clk;

video_gen u_dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .reg_data_o     (reg_data_o),
    .video_intr_o   (video_intr_o),
    .vram_sel_o     (vram_sel_o),
    .vram_addr_o    (vram_addr_o),
    .vram_data_i    (vram_data),
    .color_index_o  (color_index_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o)
);

tb_vram_model u_vram (
    .clk            (clk),
    .sel_i          (vram_sel_o),
    .addr_i         (vram_addr_o),
    .data_o         (vram_data)
);

// taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v          = {v[14:0], lfsr_state[15]};
        lfsr_state = lfsr_next(lfsr_state);             // one step per bit
    end
    return v;
endfunction

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
        errors++;
        report_failure($sformatf("Fail at %0d ns: %s, got 0x%0h expected 0x%0h",
                                 $time, msg, got, exp));
    end
endtask

task automatic write_reg(input logic [5:0] num, input logic [15:0] data);
    @(negedge clk);
    reg_wr_en_i = 1'b1;
    reg_num_i   = num;
    reg_data_i  = data;
    @(negedge clk);
    reg_wr_en_i = 1'b0;
endtask

task automatic check_reg(input logic [5:0] num, input logic [15:0] exp);
    @(negedge clk);
    reg_num_i = num;
    @(negedge clk);                                     // data one clock later
    check(reg_data_o, exp, $sformatf("read of register 0x%0h", num));
endtask

task automatic set_config(input logic [7:0] border, input logic [4:0] left,
                          input logic [4:0] right, input logic [15:0] start,
                          input logic [15:0] len, input logic [7:0] cb, input logic blank);
    write_reg(xvid_pkg::XR_VID_CTRL, {8'h00, border});
    write_reg(xvid_pkg::XR_VID_LEFT, 16'(left));
    write_reg(xvid_pkg::XR_VID_RIGHT, 16'(right));
    write_reg(xvid_pkg::XR_PA_DISP_ADDR, start);
    write_reg(xvid_pkg::XR_PA_LINE_LEN, len);
    write_reg(xvid_pkg::XR_PA_GFX_CTRL, {cb, blank, 7'h00});
    cfg_border = border;
    cfg_left   = left;
    cfg_right  = right;
    cfg_start  = start;
    cfg_len    = len;
    cfg_cb     = cb;
    cfg_blank  = blank;
endtask

// returns at the first falling edge with vsync_o high
task automatic wait_vsync_rise();
    do @(negedge clk); while (vsync_o);
    do @(negedge clk); while (!vsync_o);
endtask

function automatic xvid_pkg::color_t expected_pixel(input int x, input int y);
    logic [15:0] addr;
    logic [15:0] word;
    logic [7:0]  pix;
    addr = cfg_start + cfg_len * 16'(y) + 16'(x / 2);
    word = (addr * 16'd3) ^ 16'hA5C3;
    pix  = (x % 2 == 0) ? word[15:8] : word[7:0];   // high byte first
    if (cfg_blank || x < cfg_left || x >= cfg_right) begin
        return cfg_border;
    end
    return pix ^ cfg_cb;
endfunction

// n-th data enable cycle of the frame is pixel n
task automatic capture_frame();
    int n;
    n = 0;
    wait_vsync_rise();
    while (n < FRAME_PIX) begin
        @(negedge clk);
        if (dv_de_o) begin
            frame_pix[n] = color_index_o;
            n++;
        end
    end
endtask

task automatic check_frame(input string what);
    capture_frame();
    for (int y = 0; y < xvid_pkg::V_VISIBLE; y++) begin
        for (int x = 0; x < xvid_pkg::H_VISIBLE; x++) begin
            check(frame_pix[y * xvid_pkg::H_VISIBLE + x], expected_pixel(x, y),
                  $sformatf("%s pixel x=%0d y=%0d", what, x, y));
        end
    end
endtask

task automatic reset_defaults();
    check_reg(xvid_pkg::XR_VID_CTRL, xvid_pkg::BORDER_RESET);
    check_reg(xvid_pkg::XR_VID_LEFT, 16'h0000);
    check_reg(xvid_pkg::XR_VID_RIGHT, xvid_pkg::H_VISIBLE);
    check_reg(xvid_pkg::XR_PA_GFX_CTRL, 16'h0080);  // blank set
    check_reg(xvid_pkg::XR_PA_DISP_ADDR, 16'h0000);
    check_reg(xvid_pkg::XR_PA_LINE_LEN, xvid_pkg::LINE_LEN_RESET);
    cfg_border = xvid_pkg::BORDER_RESET;
    cfg_left   = 5'd0;
    cfg_right  = 5'(xvid_pkg::H_VISIBLE);
    cfg_start  = 16'h0000;
    cfg_len    = xvid_pkg::LINE_LEN_RESET;
    cfg_cb     = 8'h00;
    cfg_blank  = 1'b1;
    check_frame("reset frame");
endtask

task automatic write_read_back(input logic [5:0] num, input logic [15:0] mask);
    logic [15:0] val;
    val = rand_bits(16);
    write_reg(num, val);
    check_reg(num, val & mask);
endtask

task automatic register_readback();
    int k;
    write_read_back(xvid_pkg::XR_VID_CTRL, 16'h00FF);
    write_read_back(xvid_pkg::XR_VID_LEFT, HRES_MASK);
    write_read_back(xvid_pkg::XR_VID_RIGHT, HRES_MASK);
    write_read_back(xvid_pkg::XR_PA_GFX_CTRL, 16'hFF80);
    write_read_back(xvid_pkg::XR_PA_DISP_ADDR, 16'hFFFF);
    write_read_back(xvid_pkg::XR_PA_LINE_LEN, 16'hFFFF);
    check_reg(6'h01, 16'h0000);
    check_reg(6'h02, 16'h0000);
    check_reg(6'h11, 16'h0000);
    check_reg(6'h20, 16'h0000);
    check_reg(6'h3F, 16'h0000);
    // vsync_o rises VIDEO_LAT clocks into the sync line
    repeat (4) begin
        k = rand_bits(7);
        wait_vsync_rise();
        repeat (k) @(negedge clk);
        reg_num_i = xvid_pkg::XR_SCANLINE;
        @(negedge clk);
        check(reg_data_o, (xvid_pkg::V_SYNC_LINE + (VIDEO_LAT + k) / xvid_pkg::H_TOTAL)
              % xvid_pkg::V_TOTAL, $sformatf("scanline %0d clocks after vsync", k));
    end
endtask

task automatic bitmap_pixels();
    repeat (2) begin
        set_config(rand_bits(8), 5'd0, 5'(xvid_pkg::H_VISIBLE), rand_bits(16),
                   rand_bits(16), rand_bits(8), 1'b0);
        check_frame("bitmap");
    end
endtask

task automatic border_window();
    set_config(rand_bits(8), 5'd3, 5'd11, rand_bits(16), rand_bits(6), rand_bits(8), 1'b0);
    check_frame("border window");
endtask

task automatic sync_and_intr();
    int   de_total;
    int   hs_total;
    int   hs_rises;
    int   vs_total;
    int   intr_total;
    int   de_at_intr;
    int   line_de;
    int   de_lines;
    int   hb_active;
    int   vb_active;
    logic prev_hs;
    repeat (2) begin
        wait_vsync_rise();
        de_total   = 0;
        hs_total   = 0;
        hs_rises   = 0;
        vs_total   = 0;
        intr_total = 0;
        de_at_intr = 0;
        line_de    = 0;
        de_lines   = 0;
        hb_active  = 0;
        vb_active  = 0;
        prev_hs    = 1'b0;
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            if (c != 0) begin
                @(negedge clk);
            end
            if (hsync_o && !prev_hs) begin              // new line
                hs_rises++;
                if (line_de != 0) begin
                    check(line_de, xvid_pkg::H_VISIBLE, "data enable cycles in a line");
                    de_lines++;
                end
                line_de = 0;
            end
            prev_hs  = hsync_o;
            hs_total += hsync_o;
            vs_total += vsync_o;
            if (!h_blank_o) begin
                hb_active++;
            end
            if (!v_blank_o) begin
                vb_active++;
            end
            if (dv_de_o) begin
                check({h_blank_o, v_blank_o}, 2'b00, "blank during data enable");
                de_total++;
                line_de++;
            end
            if (video_intr_o) begin
                intr_total++;
                de_at_intr = de_total;
            end
        end
        check(hs_rises, xvid_pkg::V_TOTAL, "hsync pulses per frame");
        check(hs_total, (xvid_pkg::H_SYNC_END - xvid_pkg::H_SYNC_START) * xvid_pkg::V_TOTAL,
              "hsync cycles per frame");
        check(vs_total, xvid_pkg::H_TOTAL, "vsync cycles per frame");
        check(hb_active, xvid_pkg::H_VISIBLE * xvid_pkg::V_TOTAL,
              "cycles without horizontal blank per frame");
        check(vb_active, xvid_pkg::V_VISIBLE * xvid_pkg::H_TOTAL,
              "cycles without vertical blank per frame");
        check(de_lines, xvid_pkg::V_VISIBLE, "lines with data enable");
        check(de_total, FRAME_PIX, "data enable cycles per frame");
        check(intr_total, 1, "interrupt cycles per frame");
        // intr trails end_of_visible by one clock and the video outputs by two
        check(de_at_intr, FRAME_PIX - (VIDEO_LAT - 1), "data enable count at interrupt");
    end
endtask

initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog timeout: the tests did not finish in time");
end

initial begin
    reset_i     = 1'b1;
    reg_wr_en_i = 1'b0;
    reg_num_i   = '0;
    reg_data_i  = '0;
    repeat (RESET_CYCLES) begin
        @(negedge clk);
        check(video_intr_o, 1'b0, "interrupt during reset");
    end
    check({vram_sel_o, hsync_o, vsync_o, dv_de_o}, 4'b0000, "video outputs in reset");
    reset_i = 1'b0;
    reset_defaults();
    register_readback();
    bitmap_pixels();
    border_window();
    sync_and_intr();
    if (errors == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- tb_vram_model.sv
// tb_vram_model
// testbench VRAM: answers every read one clock after the select with a
// word made from the address (address times 3, xor 0xA5C3)
`default_nettype none
`timescale 1ns/1ps

module tb_vram_model (
    input  wire logic               clk,
    input  wire logic               sel_i,
    input  wire xvid_pkg::addr_t    addr_i,
    output xvid_pkg::word_t         data_o
);

always_ff @(posedge clk) begin
    if (sel_i) begin
        data_o <= (addr_i * 16'd3) ^ 16'hA5C3;          // keeps low 16 bits
    end
end

endmodule

`default_nettype wire

//--- video_bitmap.sv
// video_bitmap
// bitmap playfield: fetches VRAM words during the fetch window, shifts out
// two 8-bit pixels per word with colorbase and draws the border
// fixed two clock latency from timing sample to color index
`default_nettype none
`timescale 1ns/1ps

module video_bitmap (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xvid_pkg::vid_timing_t  timing_i,
    input  wire xvid_pkg::vid_cfg_t     vid_cfg_i,
    input  wire xvid_pkg::pf_cfg_t      pf_cfg_i,
    input  wire xvid_pkg::word_t        vram_data_i,    // read data, one clock after select
    output logic                        vram_sel_o,
    output xvid_pkg::addr_t             vram_addr_o,
    output xvid_pkg::color_t            color_index_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o,
    output logic                        h_blank_o,
    output logic                        v_blank_o
);

xvid_pkg::hres_t    fetch_rel;                          // h_count from window start
logic               fetch_go;                           // issue a word read
xvid_pkg::addr_t    line_addr;                          // first word of this line
xvid_pkg::addr_t    fetch_offset;                       // words issued this line
logic [2:0]         fetch_pipe;                         // data on bus, word held, load
xvid_pkg::word_t    data_word;                          // returned VRAM word
xvid_pkg::word_t    shift_word;                         // high byte is current pixel

xvid_pkg::hres_t    pix_x;                              // visible x of stage 1 pixel
logic               hsync_q;
logic               vsync_q;
logic               dv_de_q;
logic               h_blank_q;
logic               v_blank_q;
logic               in_window;
xvid_pkg::color_t   pix_color;

// one read every other clock inside the window
assign fetch_rel = timing_i.h_count - xvid_pkg::hres_t'(xvid_pkg::H_MEM_BEGIN);
assign fetch_go  = timing_i.v_visible && !pf_cfg_i.blank && !fetch_rel[0]
                && (fetch_rel < xvid_pkg::hres_t'(xvid_pkg::H_MEM_END - xvid_pkg::H_MEM_BEGIN));

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o   <= 1'b0;
        fetch_pipe   <= '0;
        line_addr    <= '0;
        fetch_offset <= '0;
    end else begin
        vram_sel_o <= fetch_go;
        fetch_pipe <= {fetch_pipe[1:0], vram_sel_o};
        if (fetch_go) begin
            fetch_offset <= fetch_offset + 1'b1;
        end
        if (timing_i.end_of_frame) begin
            line_addr    <= pf_cfg_i.start_addr;        // back to top of bitmap
            fetch_offset <= '0;
        end else if (timing_i.end_of_line) begin
            fetch_offset <= '0;
            if (timing_i.v_visible) begin
                line_addr <= line_addr + pf_cfg_i.line_len;
            end
        end
    end
end

// word pipeline: address, returned word, then pixel shifter
always_ff @(posedge clk) begin
    vram_addr_o <= line_addr + fetch_offset;
    if (fetch_pipe[0]) begin
        data_word <= vram_data_i;
    end
    if (fetch_pipe[2]) begin
        shift_word <= data_word;                        // lands just before its first pixel
    end else begin
        shift_word <= {shift_word[xvid_pkg::COLOR_W-1:0], {xvid_pkg::COLOR_W{1'b0}}};
    end
end

assign in_window = (pix_x >= vid_cfg_i.vid_left) && (pix_x < vid_cfg_i.vid_right);
assign pix_color = (pf_cfg_i.blank || !in_window) ? vid_cfg_i.border_color
                 : shift_word[xvid_pkg::WORD_W-1 -: xvid_pkg::COLOR_W] ^ pf_cfg_i.colorbase;

always_ff @(posedge clk) begin
    pix_x         <= timing_i.h_count - xvid_pkg::hres_t'(xvid_pkg::H_OFFSCREEN);
    color_index_o <= pix_color;
end

// sync and blank follow the pixel through both stages
always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_q   <= 1'b0;
        vsync_q   <= 1'b0;
        dv_de_q   <= 1'b0;
        h_blank_q <= 1'b1;
        v_blank_q <= 1'b1;
        hsync_o   <= 1'b0;
        vsync_o   <= 1'b0;
        dv_de_o   <= 1'b0;
        h_blank_o <= 1'b1;
        v_blank_o <= 1'b1;
    end else begin
        hsync_q   <= timing_i.hsync;
        vsync_q   <= timing_i.vsync;
        dv_de_q   <= timing_i.dv_de;
        h_blank_q <= ~timing_i.h_visible;
        v_blank_q <= ~timing_i.v_visible;
        hsync_o   <= hsync_q;
        vsync_o   <= vsync_q;
        dv_de_o   <= dv_de_q;
        h_blank_o <= h_blank_q;
        v_blank_o <= v_blank_q;
    end
end

endmodule

`default_nettype wire

//--- video_gen.sv
// video_gen
// top level of the bitmap video generator: raster timing, configuration
// registers and one bitmap playfield reading an external VRAM
`default_nettype none
`timescale 1ns/1ps

module video_gen (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           reg_wr_en_i,
    input  wire logic [xvid_pkg::REG_NUM_W-1:0] reg_num_i,
    input  wire xvid_pkg::word_t                reg_data_i,
    output xvid_pkg::word_t                     reg_data_o,
    output logic                                video_intr_o,   // end of visible area
    output logic                                vram_sel_o,
    output xvid_pkg::addr_t                     vram_addr_o,
    input  wire xvid_pkg::word_t                vram_data_i,
    output xvid_pkg::color_t                    color_index_o,
    output logic                                hsync_o,
    output logic                                vsync_o,
    output logic                                dv_de_o,
    output logic                                h_blank_o,
    output logic                                v_blank_o
);

xvid_pkg::vid_timing_t  timing;
xvid_pkg::vid_cfg_t     vid_cfg;
xvid_pkg::pf_cfg_t      pf_cfg;

video_timing u_timing (
    .clk            (clk),
    .reset_i        (reset_i),
    .timing_o       (timing)
);

video_regs u_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .timing_i       (timing),
    .reg_data_o     (reg_data_o),
    .video_intr_o   (video_intr_o),
    .vid_cfg_o      (vid_cfg),
    .pf_cfg_o       (pf_cfg)
);

video_bitmap u_bitmap (
    .clk            (clk),
    .reset_i        (reset_i),
    .timing_i       (timing),
    .vid_cfg_i      (vid_cfg),
    .pf_cfg_i       (pf_cfg),
    .vram_data_i    (vram_data_i),
    .vram_sel_o     (vram_sel_o),
    .vram_addr_o    (vram_addr_o),
    .color_index_o  (color_index_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o)
);

endmodule

`default_nettype wire

//--- video_regs.sv
// video_regs
// video configuration registers: strobe writes, reads registered one clock
// after the register number, and the end-of-visible interrupt pulse
`default_nettype none
`timescale 1ns/1ps

module video_regs (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           reg_wr_en_i,    // write strobe
    input  wire logic [xvid_pkg::REG_NUM_W-1:0] reg_num_i,
    input  wire xvid_pkg::word_t                reg_data_i,
    input  wire xvid_pkg::vid_timing_t          timing_i,
    output xvid_pkg::word_t                     reg_data_o,     // read data, one clock late
    output logic                                video_intr_o,
    output xvid_pkg::vid_cfg_t                  vid_cfg_o,
    output xvid_pkg::pf_cfg_t                   pf_cfg_o
);

xvid_pkg::word_t    rd_data;                            // selected read value

// register writes
always_ff @(posedge clk) begin
    if (reset_i) begin
        video_intr_o           <= 1'b0;
        vid_cfg_o.border_color <= xvid_pkg::color_t'(xvid_pkg::BORDER_RESET);
        vid_cfg_o.vid_left     <= '0;
        vid_cfg_o.vid_right    <= xvid_pkg::hres_t'(xvid_pkg::H_VISIBLE);
        pf_cfg_o.blank         <= 1'b1;                 // playfield starts blanked
        pf_cfg_o.colorbase     <= '0;
        pf_cfg_o.start_addr    <= '0;
        pf_cfg_o.line_len      <= xvid_pkg::word_t'(xvid_pkg::LINE_LEN_RESET);
    end else begin
        video_intr_o <= timing_i.end_of_visible;        // one clock pulse per frame
        if (reg_wr_en_i) begin
            case (reg_num_i)
                xvid_pkg::XR_VID_CTRL: begin
                    vid_cfg_o.border_color <= reg_data_i[xvid_pkg::COLOR_W-1:0];
                end
                xvid_pkg::XR_VID_LEFT: begin
                    vid_cfg_o.vid_left <= xvid_pkg::hres_t'(reg_data_i);
                end
                xvid_pkg::XR_VID_RIGHT: begin
                    vid_cfg_o.vid_right <= xvid_pkg::hres_t'(reg_data_i);
                end
                xvid_pkg::XR_PA_GFX_CTRL: begin
                    pf_cfg_o.colorbase <= reg_data_i[xvid_pkg::PA_CB_LSB +: xvid_pkg::COLOR_W];
                    pf_cfg_o.blank     <= reg_data_i[xvid_pkg::PA_BLANK_BIT];
                end
                xvid_pkg::XR_PA_DISP_ADDR: begin
                    pf_cfg_o.start_addr <= reg_data_i;
                end
                xvid_pkg::XR_PA_LINE_LEN: begin
                    pf_cfg_o.line_len <= reg_data_i;
                end
                default: begin                          // scanline is read-only
                end
            endcase
        end
    end
end

// read select, unmapped numbers give 0
always_comb begin
    rd_data = '0;
    case (reg_num_i)
        xvid_pkg::XR_VID_CTRL: begin
            rd_data[xvid_pkg::COLOR_W-1:0] = vid_cfg_o.border_color;
        end
        xvid_pkg::XR_SCANLINE: begin
            rd_data = xvid_pkg::word_t'(timing_i.v_count);
        end
        xvid_pkg::XR_VID_LEFT: begin
            rd_data = xvid_pkg::word_t'(vid_cfg_o.vid_left);
        end
        xvid_pkg::XR_VID_RIGHT: begin
            rd_data = xvid_pkg::word_t'(vid_cfg_o.vid_right);
        end
        xvid_pkg::XR_PA_GFX_CTRL: begin
            rd_data[xvid_pkg::PA_CB_LSB +: xvid_pkg::COLOR_W] = pf_cfg_o.colorbase;
            rd_data[xvid_pkg::PA_BLANK_BIT]                  = pf_cfg_o.blank;
        end
        xvid_pkg::XR_PA_DISP_ADDR: rd_data = pf_cfg_o.start_addr;
        xvid_pkg::XR_PA_LINE_LEN:  rd_data = pf_cfg_o.line_len;
        default:                   rd_data = '0;
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_data;
end

endmodule

`default_nettype wire

//--- video_timing.sv
// video_timing
// horizontal and vertical raster counters with sync pulses, visible levels
// and one-clock end of line, frame and visible area flags
`default_nettype none
`timescale 1ns/1ps

module video_timing (
    input  wire logic               clk,
    input  wire logic               reset_i,
    output xvid_pkg::vid_timing_t   timing_o
);

xvid_pkg::hres_t    h_next;                             // count for next clock
xvid_pkg::vres_t    v_next;

// all flags are derived from the counts they are registered with
function automatic xvid_pkg::vid_timing_t timing_at(input xvid_pkg::hres_t h,
                                                    input xvid_pkg::vres_t v);
    xvid_pkg::vid_timing_t t;
    logic eol;
    eol              = (h == xvid_pkg::hres_t'(xvid_pkg::H_TOTAL - 1));
    t.h_count        = h;
    t.v_count        = v;
    t.h_visible      = (h >= xvid_pkg::hres_t'(xvid_pkg::H_OFFSCREEN));
    t.v_visible      = (v < xvid_pkg::vres_t'(xvid_pkg::V_VISIBLE));
    t.end_of_line    = eol;
    t.end_of_frame   = eol && (v == xvid_pkg::vres_t'(xvid_pkg::V_TOTAL - 1));
    t.end_of_visible = eol && (v == xvid_pkg::vres_t'(xvid_pkg::V_VISIBLE - 1));
    t.hsync          = (h >= xvid_pkg::hres_t'(xvid_pkg::H_SYNC_START))
                    && (h < xvid_pkg::hres_t'(xvid_pkg::H_SYNC_END));
    t.vsync          = (v == xvid_pkg::vres_t'(xvid_pkg::V_SYNC_LINE));
    t.dv_de          = t.h_visible && t.v_visible;
    return t;
endfunction

always_comb begin
    h_next = timing_o.h_count + 1'b1;
    v_next = timing_o.v_count;
    if (timing_o.end_of_line) begin
        h_next = '0;
        if (timing_o.end_of_frame) begin
            v_next = '0;                                // wrap to top of frame
        end else begin
            v_next = timing_o.v_count + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        timing_o <= timing_at(xvid_pkg::hres_t'(0), xvid_pkg::vres_t'(0));
    end else begin
        timing_o <= timing_at(h_next, v_next);
    end
end

endmodule

`default_nettype wire

//--- xvid_pkg.sv
// xvid_pkg
// shared geometry, register numbers, field positions and types for the
// bitmap video generator
`default_nettype none

package xvid_pkg;

// raster geometry, kept tiny for short simulations
localparam int H_OFFSCREEN      = 8;                    // visible area starts here
localparam int H_TOTAL          = 24;                   // clocks per line
localparam int H_VISIBLE        = 16;                   // visible pixels per line
localparam int H_SYNC_START     = 2;
localparam int H_SYNC_END       = 5;
localparam int V_VISIBLE        = 4;                    // lines 0 to 3
localparam int V_TOTAL          = 7;                    // lines per frame
localparam int V_SYNC_LINE      = 5;
localparam int H_MEM_BEGIN      = H_OFFSCREEN - 4;      // fetch opens early
localparam int H_MEM_END        = H_TOTAL - 2;

// widths
localparam int HRES_W           = 5;
localparam int VRES_W           = 3;
localparam int WORD_W           = 16;
localparam int COLOR_W          = 8;
localparam int REG_NUM_W        = 6;

// reset values
localparam int BORDER_RESET     = 8;                    // dark grey
localparam int LINE_LEN_RESET   = 8;                    // words per line

// PA_GFX_CTRL field positions
localparam int PA_CB_LSB        = 8;                    // colorbase in 15..8
localparam int PA_BLANK_BIT     = 7;

typedef logic [HRES_W-1:0]  hres_t;
typedef logic [VRES_W-1:0]  vres_t;
typedef logic [WORD_W-1:0]  word_t;
typedef logic [WORD_W-1:0]  addr_t;                     // VRAM word address
typedef logic [COLOR_W-1:0] color_t;                    // palette index

typedef enum logic [REG_NUM_W-1:0] {
    XR_VID_CTRL     = 6'h00,
    XR_SCANLINE     = 6'h03,
    XR_VID_LEFT     = 6'h04,
    XR_VID_RIGHT    = 6'h05,
    XR_PA_GFX_CTRL  = 6'h10,
    XR_PA_DISP_ADDR = 6'h12,
    XR_PA_LINE_LEN  = 6'h13
} xr_reg_t;

typedef struct packed {
    hres_t  h_count;
    vres_t  v_count;
    logic   h_visible;
    logic   v_visible;
    logic   end_of_line;                                // last clock of a line
    logic   end_of_frame;                               // last clock of a frame
    logic   end_of_visible;                             // last pixel of last visible line
    logic   hsync;
    logic   vsync;
    logic   dv_de;
} vid_timing_t;

typedef struct packed {
    color_t border_color;
    hres_t  vid_left;                                   // first pixel inside window
    hres_t  vid_right;                                  // first pixel past window
} vid_cfg_t;

typedef struct packed {
    logic   blank;
    color_t colorbase;
    addr_t  start_addr;
    word_t  line_len;
} pf_cfg_t;

endpackage

`default_nettype wire
